// ==== logic/icache_cfg_pkg.sv ====
/*
 * icache geometry: set and way counts, address split, and the field
 * types that carve a fetch address into tag, index and word
 */
package icache_cfg_pkg;

    localparam int ADDR_W     = 32;
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 16;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;                            // 16-byte line
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;  // bits 31:8
    localparam int WORD_SEL_W = 2;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [1:0]            way_t;
    typedef logic [2:0]            plru_t;  // {ways 2/3, ways 0/1, half}

    function automatic tag_t addr_tag(input addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(input addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    // word within the line, byte bits dropped
    function automatic word_sel_t addr_word(input addr_t a);
        return a[OFFSET_W-1 -: WORD_SEL_W];
    endfunction

endpackage

// ==== logic/icache_bus_pkg.sv ====
/*
 * icache payloads: instruction word, refill line and stored tag entry,
 * shared by the way arrays and the memory ports
 */
package icache_bus_pkg;

    // one fetched instruction
    typedef logic [31:0] word_t;

    // whole refill line, word 0 in the low bits
    typedef word_t [icache_cfg_pkg::LINE_WORDS-1:0] line_t;

    // stored tag of one way
    // validity is kept apart in the line state block
    typedef icache_cfg_pkg::tag_t tag_entry_t;

endpackage

// ==== logic/ram_port_if.sv ====
`timescale 1ns/1ns
/*
 * one synchronous array port, payload type chosen per array
 */
interface ram_port_if #(
    parameter type payload_t = logic
);
    import icache_cfg_pkg::*;

    logic     en;      // read or write this cycle
    logic     we;
    index_t   addr;    // set number
    payload_t wdata;
    payload_t rdata;   // valid the cycle after en

    // controller side
    modport ctrl (output en, output we, output addr, output wdata, input rdata);

    // array side
    modport ram (input en, input we, input addr, input wdata, output rdata);

endinterface

// ==== logic/way_ram.sv ====
`timescale 1ns/1ns
/*
 * single-port set array for one way, used for both tags and lines;
 * synchronous read with one cycle of latency
 */
module way_ram #(
    parameter type entry_t = logic
) (
    input logic      clk,
    ram_port_if.ram  port
);
    import icache_cfg_pkg::*;

    entry_t mem [NUM_SETS];

    // write lands on the presenting edge
    // a read in the same cycle returns the old entry
    always_ff @(posedge clk) begin
        if (port.en) begin
            if (port.we) begin
                mem[port.addr] <= port.wdata;
            end
            port.rdata <= mem[port.addr];  // held while en is low
        end
    end

endmodule

// ==== logic/line_state.sv ====
`timescale 1ns/1ns
/*
 * per-set valid bits and tree pseudo-LRU bits, with a registered read
 * and the victim way for the set last read
 */
module line_state (
    input  logic                                clk,
    input  logic                                rst_n,
    input  icache_cfg_pkg::index_t              rd_index,
    input  logic                                fill,
    input  logic                                hit,
    input  icache_cfg_pkg::way_t                way,
    output logic [icache_cfg_pkg::NUM_WAYS-1:0] valid,
    output icache_cfg_pkg::way_t                victim
);
    import icache_cfg_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    plru_t               plru_q  [NUM_SETS];
    index_t              idx_q;     // set last read
    plru_t               cur_bits;
    plru_t               upd_bits;

    assign cur_bits = plru_q[idx_q];

    // follow the tree, 0 means the lower way
    assign victim = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

    // point the path of the used way away from it
    always_comb begin
        upd_bits    = cur_bits;
        upd_bits[0] = ~way[1];
        if (way[1]) begin
            upd_bits[2] = ~way[0];
        end else begin
            upd_bits[1] = ~way[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
            idx_q <= '0;
            valid <= '0;
        end else begin
            idx_q <= rd_index;
            valid <= valid_q[rd_index];
            if (fill) begin
                valid_q[idx_q][way] <= 1'b1;
            end
            if (fill || hit) begin
                plru_q[idx_q] <= upd_bits;
            end
        end
    end

endmodule

// ==== logic/icache_ctrl.sv ====
`timescale 1ns/1ns
/*
 * icache controller: request buffer, tag compare and word pick, plus the
 * refill and uncached sequencer that drives the way arrays
 */
module icache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  icache_cfg_pkg::addr_t               req_addr,
    input  logic                                req_uncached,
    output logic                                req_ready,
    output logic                                resp_valid,
    output icache_bus_pkg::word_t               resp_data,
    output logic                                mem_req,
    output icache_cfg_pkg::addr_t               mem_addr,
    input  logic                                mem_gnt,
    input  logic                                mem_rvalid,
    input  icache_bus_pkg::line_t               mem_rline,
    output logic                                io_req,
    output icache_cfg_pkg::addr_t               io_addr,
    input  logic                                io_gnt,
    input  logic                                io_rvalid,
    input  icache_bus_pkg::word_t               io_rdata,
    ram_port_if.ctrl                            tag_port  [icache_cfg_pkg::NUM_WAYS],
    ram_port_if.ctrl                            data_port [icache_cfg_pkg::NUM_WAYS],
    output icache_cfg_pkg::index_t              st_rd_index,
    output logic                                st_fill,
    output logic                                st_hit,
    output icache_cfg_pkg::way_t                st_way,
    input  logic [icache_cfg_pkg::NUM_WAYS-1:0] st_valid,
    input  icache_cfg_pkg::way_t                st_victim
);
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    typedef enum logic [2:0] {
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        REFILL_DONE,
        IO_REQ,
        IO_WAIT,
        IO_DONE
    } state_t;

    state_t              state;
    state_t              state_nx;
    logic                rq_valid;
    logic                rq_uncached;
    addr_t               rq_addr;     // buffered request
    word_t               io_word;
    logic                accept;
    logic                lookup;      // cached request sees its array read
    logic                rd_en;
    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit;
    way_t                hit_way;
    word_t               hit_word;
    tag_entry_t          tag_rd  [NUM_WAYS];
    line_t               line_rd [NUM_WAYS];

    assign lookup    = (state == LOOKUP) && rq_valid && !rq_uncached;
    assign hit       = |hit_vec;
    assign req_ready = (state == LOOKUP) && !(rq_valid && (rq_uncached || !hit));
    assign accept    = req_valid && req_ready;

    assign resp_valid = (lookup && hit) || (state == IO_DONE);
    assign resp_data  = (state == IO_DONE) ? io_word : hit_word;

    // requests go out the cycle the miss is seen
    assign mem_req  = (lookup && !hit) || (state == REFILL_REQ);
    assign mem_addr = {addr_tag(rq_addr), addr_index(rq_addr), {OFFSET_W{1'b0}}};
    assign io_req   = ((state == LOOKUP) && rq_valid && rq_uncached) || (state == IO_REQ);
    assign io_addr  = rq_addr;

    // one index for all arrays and the line state
    assign st_rd_index = accept ? addr_index(req_addr) : addr_index(rq_addr);
    assign rd_en       = accept || (state == REFILL_DONE);  // re-read after fill
    assign st_fill     = (state == REFILL_WAIT) && mem_rvalid;
    assign st_hit      = lookup && hit;
    assign st_way      = st_fill ? st_victim : hit_way;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic wr;
        assign wr = st_fill && (st_victim == way_t'(w));

        assign tag_port[w].en     = rd_en || wr;
        assign tag_port[w].we     = wr;
        assign tag_port[w].addr   = st_rd_index;
        assign tag_port[w].wdata  = addr_tag(rq_addr);
        assign data_port[w].en    = rd_en || wr;
        assign data_port[w].we    = wr;
        assign data_port[w].addr  = st_rd_index;
        assign data_port[w].wdata = mem_rline;

        assign tag_rd[w]  = tag_port[w].rdata;
        assign line_rd[w] = data_port[w].rdata;
        assign hit_vec[w] = st_valid[w] && (tag_rd[w] == addr_tag(rq_addr));
    end

    // hit is one-hot, so OR the matching way in
    always_comb begin
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way  = hit_way | way_t'(w);
                hit_word = hit_word | line_rd[w][addr_word(rq_addr)];
            end
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            LOOKUP: begin
                if (rq_valid && rq_uncached) begin
                    state_nx = io_gnt ? IO_WAIT : IO_REQ;
                end else if (lookup && !hit) begin
                    state_nx = mem_gnt ? REFILL_WAIT : REFILL_REQ;
                end
            end
            REFILL_REQ:  if (mem_gnt) state_nx = REFILL_WAIT;
            REFILL_WAIT: if (mem_rvalid) state_nx = REFILL_DONE;  // line written here
            REFILL_DONE: state_nx = LOOKUP;
            IO_REQ:      if (io_gnt) state_nx = IO_WAIT;
            IO_WAIT:     if (io_rvalid) state_nx = IO_DONE;
            IO_DONE:     state_nx = LOOKUP;
            default:     state_nx = LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= LOOKUP;
            rq_valid    <= 1'b0;
            rq_uncached <= 1'b0;
        end else begin
            state <= state_nx;
            if (accept) begin
                rq_valid    <= 1'b1;
                rq_uncached <= req_uncached;
            end else if (resp_valid) begin
                rq_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rq_addr <= req_addr;
        end
        if ((state == IO_WAIT) && io_rvalid) begin
            io_word <= io_rdata;
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/1ns
/*
 * four-way instruction cache top: controller, line state and the
 * tag and data arrays of every way
 */
module icache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // fetch side
    input  logic                  req_valid,
    input  icache_cfg_pkg::addr_t req_addr,
    input  logic                  req_uncached,
    output logic                  req_ready,
    output logic                  resp_valid,
    output icache_bus_pkg::word_t resp_data,
    // line refill
    output logic                  mem_req,
    output icache_cfg_pkg::addr_t mem_addr,
    input  logic                  mem_gnt,
    input  logic                  mem_rvalid,
    input  icache_bus_pkg::line_t mem_rline,
    // single-word uncached port
    output logic                  io_req,
    output icache_cfg_pkg::addr_t io_addr,
    input  logic                  io_gnt,
    input  logic                  io_rvalid,
    input  icache_bus_pkg::word_t io_rdata
);
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    index_t              st_rd_index;
    logic                st_fill;
    logic                st_hit;
    way_t                st_way;
    logic [NUM_WAYS-1:0] st_valid;
    way_t                st_victim;

    ram_port_if #(.payload_t(tag_entry_t)) tag_if  [NUM_WAYS] ();
    ram_port_if #(.payload_t(line_t))      data_if [NUM_WAYS] ();

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_uncached(req_uncached),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_gnt     (mem_gnt),
        .mem_rvalid  (mem_rvalid),
        .mem_rline   (mem_rline),
        .io_req      (io_req),
        .io_addr     (io_addr),
        .io_gnt      (io_gnt),
        .io_rvalid   (io_rvalid),
        .io_rdata    (io_rdata),
        .tag_port    (tag_if),
        .data_port   (data_if),
        .st_rd_index (st_rd_index),
        .st_fill     (st_fill),
        .st_hit      (st_hit),
        .st_way      (st_way),
        .st_valid    (st_valid),
        .st_victim   (st_victim)
    );

    line_state u_state (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_index(st_rd_index),
        .fill    (st_fill),
        .hit     (st_hit),
        .way     (st_way),
        .valid   (st_valid),
        .victim  (st_victim)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        way_ram #(.entry_t(tag_entry_t)) u_tag (
            .clk (clk),
            .port(tag_if[w])
        );
        way_ram #(.entry_t(line_t)) u_data (
            .clk (clk),
            .port(data_if[w])
        );
    end

endmodule

// ==== tb/icache_checker.sv ====
`timescale 1ns/1ns
/*
 * protocol checks for the icache: memory request hold rules,
 * line alignment and when a response may appear
 */
module icache_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  req_valid,
    input icache_cfg_pkg::addr_t req_addr,
    input logic                  req_ready,
    input logic                  resp_valid,
    input logic                  mem_req,
    input icache_cfg_pkg::addr_t mem_addr,
    input logic                  mem_gnt,
    input logic                  mem_rvalid,
    input logic                  io_req,
    input icache_cfg_pkg::addr_t io_addr,
    input logic                  io_gnt,
    input logic                  io_rvalid
);
    import icache_cfg_pkg::*;

    int    err_count = 0;
    logic  returned;  // a memory return since the last response
    addr_t acc_addr;  // last accepted fetch address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            returned <= 1'b0;
        end else if (resp_valid) begin
            returned <= 1'b0;
        end else if (mem_rvalid || io_rvalid) begin
            returned <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_addr <= '0;
        end else if (req_valid && req_ready) begin
            acc_addr <= req_addr;
        end
    end

    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_addr))
        else begin
            err_count++;
            $error("mem_req dropped or mem_addr changed before grant");
        end

    a_io_hold: assert property (@(posedge clk) disable iff (!rst_n)
        io_req && !io_gnt |=> io_req && $stable(io_addr))
        else begin
            err_count++;
            $error("io_req dropped or io_addr changed before grant");
        end

    // refill asks for the whole line of the missed fetch
    a_line_align: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_addr == {acc_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}})
        else begin
            err_count++;
            $error("mem_addr is not the aligned line of the missed fetch");
        end

    a_resp_rule: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !req_ready |-> returned)
        else begin
            err_count++;
            $error("resp_valid while busy with no memory return");
        end

endmodule

bind icache_top icache_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .resp_valid(resp_valid),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_gnt   (mem_gnt),
    .mem_rvalid(mem_rvalid),
    .io_req    (io_req),
    .io_addr   (io_addr),
    .io_gnt    (io_gnt),
    .io_rvalid (io_rvalid)
);

// ==== tb/tb_icache.sv ====
`timescale 1ns/1ns
/*
 * icache testbench: table of fetches against refill and io memory models,
 * with a reference tag and PLRU model predicting data and refills
 */
module tb_icache;
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int N_ENTRIES = 21;

    typedef struct packed {
        addr_t addr;
        logic  unc;
        logic  refill;   // expected line refill
    } stim_t;

    typedef struct {
        addr_t addr;
        logic  unc;
        logic  refill;
        word_t data;
        int    refills;  // running totals after this entry
        int    ios;
        int    acc_cyc;
    } pend_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  req_valid;
    addr_t req_addr;
    logic  req_uncached;
    logic  req_ready;
    logic  resp_valid;
    word_t resp_data;
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_gnt;
    logic  mem_rvalid;
    line_t mem_rline;
    logic  io_req;
    addr_t io_addr;
    logic  io_gnt;
    logic  io_rvalid;
    word_t io_rdata;

    int    cyc = 0;
    int    refill_cnt = 0;
    int    io_cnt = 0;
    int    refills_exp = 0;
    int    ios_exp = 0;
    int    done_cnt = 0;
    addr_t refill_addr;
    addr_t io_seen_addr;
    pend_t pend_q[$];

    // reference cache state
    tag_t  ref_tag   [NUM_SETS][NUM_WAYS];
    logic  ref_valid [NUM_SETS][NUM_WAYS];
    plru_t ref_plru  [NUM_SETS];

    stim_t stim [N_ENTRIES] = '{
        '{32'h0000_1030, 1'b0, 1'b1},  // cold miss
        '{32'h0000_1034, 1'b0, 1'b0},
        '{32'h0000_1038, 1'b0, 1'b0},
        '{32'h0000_103C, 1'b0, 1'b0},
        '{32'h0000_2040, 1'b1, 1'b0},  // uncached pair
        '{32'h0000_2044, 1'b1, 1'b0},
        '{32'h0000_2040, 1'b0, 1'b1},  // io left no line behind
        '{32'h0000_2048, 1'b0, 1'b0},
        '{32'h0000_0050, 1'b0, 1'b1},  // five tags into set 5
        '{32'h0000_0150, 1'b0, 1'b1},
        '{32'h0000_0250, 1'b0, 1'b1},
        '{32'h0000_0350, 1'b0, 1'b1},
        '{32'h0000_0054, 1'b0, 1'b0},
        '{32'h0000_0450, 1'b0, 1'b1},
        '{32'h0000_0050, 1'b0, 1'b0},
        '{32'h0000_0158, 1'b0, 1'b1},
        '{32'h0000_0258, 1'b0, 1'b0},
        '{32'h0000_045C, 1'b0, 1'b0},
        '{32'h0000_035C, 1'b0, 1'b1},
        '{32'h0000_1030, 1'b0, 1'b0},
        '{32'h0000_0050, 1'b0, 1'b1}
    };

    icache_top DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // n clock edges, landing just after the last one
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // look up and update the reference model, returns 1 on a refill
    function automatic logic ref_access(input addr_t a);
        index_t s;
        tag_t   t;
        way_t   w;
        logic   hit;
        s   = a[7:4];
        t   = a[31:8];
        w   = '0;
        hit = 1'b0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (ref_valid[s][i] && ref_tag[s][i] == t) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            if (ref_plru[s][0] == 1'b0) begin
                w = {1'b0, ref_plru[s][1]};  // lower pair
            end else begin
                w = {1'b1, ref_plru[s][2]};
            end
            ref_valid[s][w] = 1'b1;
            ref_tag[s][w]   = t;
        end
        ref_plru[s][0] = ~w[1];  // point away from w
        if (w[1]) begin
            ref_plru[s][2] = ~w[0];
        end else begin
            ref_plru[s][1] = ~w[0];
        end
        return !hit;
    endfunction

    task automatic expect_entry(input stim_t s);
        pend_t p;
        logic  miss;
        miss = 1'b0;
        if (s.unc) begin
            ios_exp++;
        end else begin
            miss = ref_access(s.addr);
        end
        if (miss !== s.refill) begin
            abort_run($sformatf("table refill flag for 0x%08h disagrees with the model", s.addr));
        end
        if (miss) begin
            refills_exp++;
        end
        p.addr    = s.addr;
        p.unc     = s.unc;
        p.refill  = miss;
        p.refills = refills_exp;
        p.ios     = ios_exp;
        p.acc_cyc = cyc;
        p.data    = s.unc ? ~s.addr : (s.addr ^ 32'h5A5A_0000);
        pend_q.push_back(p);
    endtask

    initial begin : refill_model
        addr_t a;
        line_t l;
        forever begin
            step(1);
            if (mem_req) begin
                a = mem_addr;
                step($urandom_range(0, 5));  // zero grants in the request cycle
                mem_gnt = 1'b1;
                step(1);
                mem_gnt     = 1'b0;
                refill_cnt  = refill_cnt + 1;
                refill_addr = a;
                step($urandom_range(0, 5));
                for (int k = 0; k < LINE_WORDS; k++) begin
                    l[k] = (a + 4 * k) ^ 32'h5A5A_0000;
                end
                mem_rline  = l;
                mem_rvalid = 1'b1;
                step(1);
                mem_rvalid = 1'b0;
            end
        end
    end

    initial begin : io_model
        addr_t a;
        forever begin
            step(1);
            if (io_req) begin
                a = io_addr;
                step($urandom_range(0, 5));
                io_gnt = 1'b1;
                step(1);
                io_gnt       = 1'b0;
                io_cnt       = io_cnt + 1;
                io_seen_addr = a;
                step($urandom_range(0, 5));
                io_rdata  = ~a;
                io_rvalid = 1'b1;
                step(1);
                io_rvalid = 1'b0;
            end
        end
    end

    initial begin : resp_monitor
        pend_t p;
        forever begin
            @(negedge clk);
            if (resp_valid) begin
                if (pend_q.size() == 0) begin
                    abort_run("response arrived with no request outstanding");
                end
                p = pend_q.pop_front();
                check_word("resp_data", resp_data, p.data);
                if (refill_cnt != p.refills || io_cnt != p.ios) begin
                    abort_run($sformatf("memory request count wrong at 0x%08h", p.addr));
                end
                if (p.refill) begin
                    check_addr("mem_addr", refill_addr, {p.addr[31:4], 4'h0});
                end
                if (p.unc) begin
                    check_addr("io_addr", io_seen_addr, p.addr);
                end
                if (!p.refill && !p.unc && cyc != p.acc_cyc) begin
                    abort_run($sformatf("hit at 0x%08h not answered in the next cycle", p.addr));
                end
                done_cnt++;
            end
        end
    end

    initial begin : watchdog
        repeat (N_ENTRIES * 40 + 200) @(posedge clk);
        abort_run("timeout: responses still outstanding");
    end

    initial begin : main_seq
        void'($urandom(80433));
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_uncached = 1'b0;
        mem_gnt      = 1'b0;
        mem_rvalid   = 1'b0;
        mem_rline    = '0;
        io_gnt       = 1'b0;
        io_rvalid    = 1'b0;
        io_rdata     = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("req_ready", req_ready, 1'b1);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("io_req", io_req, 1'b0);
        check_bit("resp_valid", resp_valid, 1'b0);
        step(1);
        for (int i = 0; i < N_ENTRIES; i++) begin
            req_valid    = 1'b1;
            req_addr     = stim[i].addr;
            req_uncached = stim[i].unc;
            do @(negedge clk); while (!req_ready);  // accepted on the next edge
            step(1);
            expect_entry(stim[i]);
        end
        req_valid = 1'b0;
        wait (done_cnt == N_ENTRIES);
        step(2);
        if (DUT.u_checker.err_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("protocol assertions fired in the checker");
        end
    end

endmodule

// ==== icache_sys.f ====
logic/icache_cfg_pkg.sv
logic/icache_bus_pkg.sv
logic/ram_port_if.sv
logic/way_ram.sv
logic/line_state.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/icache_checker.sv
tb/tb_icache.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_icache
RTL_TOP    := icache_top
FILELIST   := icache_sys.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
